//--- serial_arb_pkg.sv
// two masters and ids 1 to 3 only (0 is no request); frames leave bit 0 first, patterns read oldest bit left
package serial_arb_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////
  localparam int NO_SLAVES   = 3;
  localparam int NO_MASTERS  = 2;
  localparam int S_ID_WIDTH  = $clog2(NO_SLAVES + 1);
  localparam int FRAME_WIDTH = 3;
  localparam int PAT_WIDTH   = 3;                      // input pattern window
  localparam int GAP_WIDTH   = $clog2(FRAME_WIDTH);    // frame bits still queued

  // frames to a master
  localparam logic [FRAME_WIDTH-1:0] FR_ZERO  = 3'b000;  // reset or end
  localparam logic [FRAME_WIDTH-1:0] FR_GRANT = 3'b011;  // line sees 1,1,0
  localparam logic [FRAME_WIDTH-1:0] FR_OPEN  = 3'b111;
  localparam logic [FRAME_WIDTH-1:0] FR_STOP  = 3'b010;

  // patterns from a master
  localparam logic [PAT_WIDTH-1:0] PAT_REQ  = 3'b111;
  localparam logic [PAT_WIDTH-1:0] PAT_ACK  = 3'b101;
  localparam logic [PAT_WIDTH-1:0] PAT_NAK  = 3'b110;
  localparam logic [PAT_WIDTH-1:0] PAT_DONE = 3'b010;
  localparam logic [1:0]           PAT_END  = 2'b01;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    STOP_P = 2'b10,  // preempted
    CLEAR  = 2'b11   // bus granted
  } cmd_e;

  typedef enum logic [1:0] {
    END_COM  = 2'b00,
    NAK      = 2'b01,
    WAIT_ACK = 2'b10,
    COM      = 2'b11
  } com_state_e;

  // ST_ prefix keeps COM free for the status code
  typedef enum logic [2:0] {
    ST_RST, ST_START, ST_ALLOC1, ST_ALLOC2, ST_ACK, ST_COM, ST_DONE, ST_OVER
  } port_state_e;

  typedef enum logic [1:0] {
    ARB_FREE, ARB_GRANT, ARB_BUSY, ARB_STOP
  } arb_state_e;

  typedef struct packed {
    logic [S_ID_WIDTH-1:0] id;         // nonzero only while waiting for a grant
    com_state_e            com_state;
    logic                  done;       // one cycle, after a stop
  } port_status_t;

endpackage

//--- frame_shifter.sv
// loads must be at least three cycles apart; a new load may land while the last bit is on the line
`timescale 1ns/10ps

module frame_shifter (
  input  logic                                   clk,
  input  logic                                   rstN,
  input  logic [serial_arb_pkg::FRAME_WIDTH-1:0] din,
  input  logic                                   load,
  output logic                                   dout
);
  import serial_arb_pkg::*;

  logic [FRAME_WIDTH-1:0] shreg;
  logic [GAP_WIDTH-1:0]   busy_cnt;  // bits queued behind the one on the line

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      shreg    <= '0;
      busy_cnt <= '0;
    end else if (load) begin
      shreg    <= din;
      busy_cnt <= GAP_WIDTH'(FRAME_WIDTH - 1);
    end else begin
      shreg <= {1'b0, shreg[FRAME_WIDTH-1:1]};  // zero fill, line idles low
      if (busy_cnt != '0) busy_cnt <= busy_cnt - 1'b1;
    end
  end

  assign dout = shreg[0];

  // the port spaces its frames, never cut one short
  a_no_overlap: assert property (@(posedge clk) disable iff (!rstN)
    load |-> (busy_cnt == '0));

endmodule

//--- master_port.sv
// the two id bits must directly follow 111, and a master stays idle (0) while a frame arrives
`timescale 1ns/10ps

module master_port (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         port_in,
  output logic                         port_out,
  input  serial_arb_pkg::cmd_e         cmd,
  output serial_arb_pkg::port_status_t status
);
  import serial_arb_pkg::*;

  port_state_e            state;
  port_state_e            next_state;
  logic [PAT_WIDTH-1:0]   input_buf;  // newest bit in bit 0
  logic                   request;
  logic [S_ID_WIDTH-1:0]  req_id;
  com_state_e             com_state;
  logic                   done;
  logic                   open_pend;  // ack seen, open frame still to go
  logic [GAP_WIDTH-1:0]   gap_cnt;
  logic                   can_load;
  logic [FRAME_WIDTH-1:0] frame;
  logic                   load;

  frame_shifter out_shifter_i (
    .clk  (clk),
    .rstN (rstN),
    .din  (frame),
    .load (load),
    .dout (port_out)
  );

  // same spacing the shifter expects
  assign can_load = (gap_cnt == '0);

  //////////////////////////////
  // next state and frames
  //////////////////////////////
  always_comb begin
    next_state = state;
    frame      = FR_ZERO;
    load       = 1'b0;
    case (state)
      ST_RST: begin
        load       = 1'b1;  // one zero frame after reset
        next_state = ST_START;
      end
      ST_START: if (request) next_state = ST_ALLOC1;
      ST_ALLOC1: begin
        // id 0 means no slave, drop it
        if (input_buf[S_ID_WIDTH-1:0] != '0) next_state = ST_ALLOC2;
        else next_state = ST_START;
      end
      ST_ALLOC2: begin
        if (cmd == CLEAR && can_load) begin
          frame      = FR_GRANT;
          load       = 1'b1;
          next_state = ST_ACK;
        end
      end
      ST_ACK: begin
        if (input_buf == PAT_NAK) next_state = ST_OVER;
        else if (input_buf == PAT_ACK) next_state = ST_COM;
      end
      ST_COM: begin
        if (can_load) begin
          if (open_pend) begin
            frame = FR_OPEN;
            load  = 1'b1;
          end else if (com_state == END_COM) begin
            load       = 1'b1;  // zero frame closes
            next_state = ST_OVER;
          end else if (cmd == STOP_P) begin
            frame      = FR_STOP;
            load       = 1'b1;
            next_state = ST_DONE;
          end
        end
      end
      ST_DONE: if (done) next_state = ST_ALLOC2;  // request stays, wait again
      ST_OVER: next_state = ST_START;
    endcase
  end

  //////////////////////////////
  // state, decode and status
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= ST_RST;
      input_buf <= '0;
      request   <= 1'b0;
      com_state <= END_COM;
      done      <= 1'b0;
      open_pend <= 1'b0;
      gap_cnt   <= '0;
    end else begin
      state     <= next_state;
      input_buf <= {input_buf[PAT_WIDTH-2:0], port_in};
      request   <= (state == ST_START) && (input_buf == PAT_REQ);
      done      <= (state == ST_DONE) && (input_buf == PAT_DONE) && !done;

      if (load) gap_cnt <= GAP_WIDTH'(FRAME_WIDTH - 1);
      else if (gap_cnt != '0) gap_cnt <= gap_cnt - 1'b1;

      case (state)
        ST_ALLOC2: if (load) com_state <= WAIT_ACK;
        ST_ACK: begin
          if (next_state == ST_OVER) begin
            com_state <= NAK;
          end else if (next_state == ST_COM) begin
            com_state <= COM;
            open_pend <= 1'b1;
          end
        end
        ST_COM: begin
          if (load && open_pend) open_pend <= 1'b0;
          // end pattern only counts once the open frame is out
          if (next_state == ST_COM && !open_pend && input_buf[1:0] == PAT_END) begin
            com_state <= END_COM;
          end
        end
        ST_DONE: if (input_buf == PAT_DONE && !done) com_state <= END_COM;
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_ALLOC1) req_id <= input_buf[S_ID_WIDTH-1:0];
  end

  assign status.id        = (state == ST_ALLOC2) ? req_id : '0;
  assign status.com_state = com_state;
  assign status.done      = done;

  a_com_in_state: assert property (@(posedge clk) disable iff (!rstN)
    (com_state == COM) |-> (state inside {ST_COM, ST_DONE}));

endmodule

//--- arb_controller.sv
// fixed priority, master 0 highest; preempts only an owner already in communication
`timescale 1ns/10ps

module arb_controller (
  input  logic                                  clk,
  input  logic                                  rstN,
  input  serial_arb_pkg::port_status_t          status [serial_arb_pkg::NO_MASTERS],
  output serial_arb_pkg::cmd_e                  cmd    [serial_arb_pkg::NO_MASTERS],
  output logic                                  owner_valid,
  output logic                                  owner,
  output logic [serial_arb_pkg::S_ID_WIDTH-1:0] slave_id
);
  import serial_arb_pkg::*;

  arb_state_e             state;
  port_status_t           owner_st;
  logic                   pick_valid;
  logic                   pick;
  logic                   higher_wait;  // someone above the owner waits
  logic                   release_bus;
  logic                   grant_now;
  logic                   preempt;
  logic [NO_MASTERS-1:0]  clear_vec;

  assign owner_st = status[owner];

  // lowest waiting index wins
  always_comb begin
    pick_valid  = 1'b0;
    pick        = 1'b0;
    higher_wait = 1'b0;
    for (int m = NO_MASTERS - 1; m >= 0; m--) begin
      if (status[m].id != '0) begin
        pick_valid = 1'b1;
        pick       = 1'(m);
        if (m < int'(owner)) higher_wait = 1'b1;
      end
    end
  end

  //////////////////////////////
  // release, grant, preempt
  //////////////////////////////
  assign release_bus = ((state == ARB_BUSY) && (owner_st.com_state inside {END_COM, NAK}))
                    || ((state == ARB_STOP) && (owner_st.done || owner_st.com_state == END_COM));
  assign grant_now   = pick_valid && ((state == ARB_FREE) || release_bus);
  assign preempt     = (state == ARB_BUSY) && (owner_st.com_state == COM) && higher_wait;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state       <= ARB_FREE;
      owner       <= 1'b0;
      owner_valid <= 1'b0;
      slave_id    <= '0;
      for (int m = 0; m < NO_MASTERS; m++) cmd[m] <= IDLE;
    end else begin
      if (release_bus) begin
        cmd[owner]  <= IDLE;
        owner_valid <= 1'b0;
        state       <= ARB_FREE;
      end
      // clear held until the port leaves its wait
      if (state == ARB_GRANT && owner_st.id == '0) begin
        cmd[owner] <= IDLE;
        state      <= ARB_BUSY;
      end
      if (preempt) begin
        cmd[owner] <= STOP_P;  // held until done
        state      <= ARB_STOP;
      end
      if (grant_now) begin  // may follow a release in the same cycle
        cmd[pick]   <= CLEAR;
        owner       <= pick;
        owner_valid <= 1'b1;
        slave_id    <= status[pick].id;
        state       <= ARB_GRANT;
      end
    end
  end

  always_comb begin
    for (int m = 0; m < NO_MASTERS; m++) clear_vec[m] = (cmd[m] == CLEAR);
  end

  a_one_clear: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0(clear_vec));

  // a clear always goes to the recorded owner
  a_clear_owner: assert property (@(posedge clk) disable iff (!rstN)
    (|clear_vec) |-> (owner_valid && clear_vec[owner]));

endmodule

//--- serial_arbiter_top.sv
// two masters on one-bit serial lines; owner and slave_id are only meaningful while owner_valid
`timescale 1ns/10ps

module serial_arbiter_top (
  input  logic                                  clk,
  input  logic                                  rstN,
  input  logic [serial_arb_pkg::NO_MASTERS-1:0] port_in,
  output logic [serial_arb_pkg::NO_MASTERS-1:0] port_out,
  output logic                                  owner_valid,
  output logic                                  owner,
  output logic [serial_arb_pkg::S_ID_WIDTH-1:0] slave_id
);
  import serial_arb_pkg::*;

  port_status_t status [NO_MASTERS];
  cmd_e         cmd    [NO_MASTERS];

  //////////////////////////////
  // one port per master
  //////////////////////////////
  for (genvar m = 0; m < NO_MASTERS; m++) begin : g_port
    master_port port_i (
      .clk      (clk),
      .rstN     (rstN),
      .port_in  (port_in[m]),
      .port_out (port_out[m]),
      .cmd      (cmd[m]),
      .status   (status[m])
    );
  end

  arb_controller ctrl_i (
    .clk         (clk),
    .rstN        (rstN),
    .status      (status),
    .cmd         (cmd),
    .owner_valid (owner_valid),
    .owner       (owner),
    .slave_id    (slave_id)
  );

endmodule

//--- tb_master_line.sv
// sends patterns oldest bit first; only frames that put a 1 on the line are seen, a zero frame is not
`timescale 1ns/10ps

module tb_master_line (
  input  logic       clk,
  input  logic       rstN,
  input  logic       go,        // one cycle, starts pat
  input  logic [4:0] pat,       // bit len-1 leaves first
  input  logic [2:0] len,
  output logic       busy,
  output logic       line_out,  // to port_in
  input  logic       line_in,   // from port_out
  output logic       rx_valid,
  output logic [2:0] rx_frame   // bit 0 is the first bit on the line
);

  logic [4:0] tx_sr;
  logic [2:0] tx_cnt;
  logic [1:0] rx_cnt;
  logic [1:0] rx_bits;

  assign busy = (tx_cnt != 3'd0);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      tx_sr    <= '0;
      tx_cnt   <= '0;
      line_out <= 1'b0;
      rx_cnt   <= '0;
      rx_bits  <= '0;
      rx_valid <= 1'b0;
      rx_frame <= '0;
    end else begin
      if (go && !busy) begin
        tx_sr    <= pat;
        tx_cnt   <= len;
        line_out <= 1'b0;
      end else if (busy) begin
        line_out <= tx_sr[tx_cnt - 3'd1];
        tx_cnt   <= tx_cnt - 3'd1;
      end else begin
        line_out <= 1'b0;
      end

      ////////////////////////////////
      // frame decode
      ////////////////////////////////
      rx_valid <= 1'b0;
      case (rx_cnt)
        2'd0: begin
          if (line_in) begin  // first high bit opens a frame
            rx_bits <= 2'b01;
            rx_cnt  <= 2'd1;
          end
        end
        2'd1: begin
          rx_bits[1] <= line_in;
          rx_cnt     <= 2'd2;
        end
        default: begin
          rx_cnt   <= 2'd0;
          rx_valid <= 1'b1;
          // stop leads with a low bit, so its window starts one bit late
          rx_frame <= ({line_in, rx_bits} == 3'b001) ? 3'b010 : {line_in, rx_bits};
        end
      endcase
    end
  end

endmodule

//--- tb_serial_arbiter.sv
// scenarios run one after another and each ends with the bus free; timeouts are 100 cycles
`timescale 1ns/10ps

module tb_serial_arbiter;

  localparam logic [2:0] F_GRANT = 3'b011;  // line order 1,1,0
  localparam logic [2:0] F_OPEN  = 3'b111;
  localparam logic [2:0] F_STOP  = 3'b010;
  localparam int         TIMEOUT = 100;

  logic       clk;
  logic       rstN;
  logic [1:0] port_in;
  logic [1:0] port_out;
  logic       owner_valid;
  logic       owner;
  logic [1:0] slave_id;
  logic [1:0] go;
  logic [1:0] busy;
  logic [1:0] rx_valid;
  logic [4:0] pat [2];
  logic [2:0] len [2];
  logic [2:0] rx_frame [2];
  logic [2:0] rx_q [2][$];   // frames seen per master
  logic [2:0] exp_q [2][$];  // frames the model predicts
  logic [2:0] grant_q [$];   // {owner, slave_id} at each new owner
  logic [2:0] exp_grant [$];
  logic       prev_valid;
  logic       prev_owner;
  string      cur_test;
  int         errors;
  int         tests;
  int         failed_tests;

  serial_arbiter_top dut_i (
    .clk         (clk),
    .rstN        (rstN),
    .port_in     (port_in),
    .port_out    (port_out),
    .owner_valid (owner_valid),
    .owner       (owner),
    .slave_id    (slave_id)
  );

  for (genvar m = 0; m < 2; m++) begin : g_line
    tb_master_line line_i (
      .clk      (clk),
      .rstN     (rstN),
      .go       (go[m]),
      .pat      (pat[m]),
      .len      (len[m]),
      .busy     (busy[m]),
      .line_out (port_in[m]),
      .line_in  (port_out[m]),
      .rx_valid (rx_valid[m]),
      .rx_frame (rx_frame[m])
    );
  end

  always #4 clk = ~clk;

  always @(posedge clk) begin
    for (int m = 0; m < 2; m++) begin
      if (rx_valid[m]) rx_q[m].push_back(rx_frame[m]);
    end
  end

  // a handoff keeps owner_valid high, so watch the owner too
  always @(negedge clk) begin
    if (owner_valid && (!prev_valid || owner != prev_owner)) grant_q.push_back({owner, slave_id});
    prev_valid = owner_valid;
    prev_owner = owner;
  end

  function automatic logic [1:0] rand_id();
    return 2'($urandom_range(3, 1));
  endfunction

  function automatic logic rand_bit();
    return 1'($urandom_range(1, 0));
  endfunction

  ////////////////////////////////
  // line and wait helpers
  ////////////////////////////////
  task automatic send(input int m, input logic [4:0] p, input logic [2:0] n);
    int t;
    @(posedge clk);
    pat[m] <= p;
    len[m] <= n;
    go[m]  <= 1'b1;
    @(posedge clk);
    go[m] <= 1'b0;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (busy[m] && t < TIMEOUT);
    if (busy[m]) begin
      $display("ERROR %s: master %0d line still sending after %0d cycles", cur_test, m, t);
      errors++;
    end
  endtask

  task automatic wait_rx(input int m);
    int t;
    t = 0;
    while (rx_q[m].size() < exp_q[m].size() && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (rx_q[m].size() < exp_q[m].size()) begin
      $display("ERROR %s: master %0d got no frame within %0d cycles", cur_test, m, TIMEOUT);
      errors++;
    end
  endtask

  task automatic wait_free();
    int t;
    t = 0;
    while (owner_valid && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (owner_valid) begin
      $display("ERROR %s: bus never released", cur_test);
      errors++;
    end
  endtask

  ////////////////////////////////
  // reference model of the grant rules
  ////////////////////////////////
  task automatic finish_com(input int m, input logic ack);
    if (ack) begin
      send(m, 5'b00101, 3'd3);  // ack, open follows
      exp_q[m].push_back(F_OPEN);
      wait_rx(m);
      send(m, 5'b00001, 3'd2);  // end pattern 01
    end else begin
      send(m, 5'b00110, 3'd3);  // nak, no open
    end
  endtask

  task automatic run_single(input int m, input logic [1:0] id, input logic ack);
    exp_grant.push_back({1'(m), id});
    send(m, {3'b111, id}, 3'd5);
    exp_q[m].push_back(F_GRANT);
    wait_rx(m);
    if ({owner_valid, owner, slave_id} !== {1'b1, 1'(m), id}) begin
      $display("CHECK FAILED %s: valid/owner/slave_id expected %b actual %b", cur_test,
               {1'b1, 1'(m), id}, {owner_valid, owner, slave_id});
      errors++;
    end
    finish_com(m, ack);
    wait_free();
  endtask

  task automatic run_both(input logic [1:0] i0, input logic a0, input logic [1:0] i1,
                          input logic a1);
    exp_grant.push_back({1'b0, i0});  // master 0 first
    exp_grant.push_back({1'b1, i1});
    fork
      send(0, {3'b111, i0}, 3'd5);
      send(1, {3'b111, i1}, 3'd5);
    join
    exp_q[0].push_back(F_GRANT);
    wait_rx(0);
    if (rx_q[1].size() != 0) begin
      $display("ERROR %s: master 1 got a frame before master 0 ended", cur_test);
      errors++;
    end
    finish_com(0, a0);
    exp_q[1].push_back(F_GRANT);
    wait_rx(1);
    finish_com(1, a1);
    wait_free();
  endtask

  task automatic run_preempt(input logic [1:0] i0, input logic a0, input logic [1:0] i1);
    exp_grant.push_back({1'b1, i1});
    exp_grant.push_back({1'b0, i0});
    exp_grant.push_back({1'b1, i1});  // resumes with its old id
    send(1, {3'b111, i1}, 3'd5);
    exp_q[1].push_back(F_GRANT);
    wait_rx(1);
    send(1, 5'b00101, 3'd3);
    exp_q[1].push_back(F_OPEN);
    wait_rx(1);
    send(0, {3'b111, i0}, 3'd5);
    exp_q[1].push_back(F_STOP);
    wait_rx(1);
    // master 0 waits for the done of master 1
    if (rx_q[0].size() != 0 || owner !== 1'b1) begin
      $display("ERROR %s: master 0 granted before master 1 sent done", cur_test);
      errors++;
    end
    send(1, 5'b00010, 3'd3);  // done
    exp_q[0].push_back(F_GRANT);
    wait_rx(0);
    finish_com(0, a0);
    exp_q[1].push_back(F_GRANT);
    wait_rx(1);
    finish_com(1, 1'b1);
    wait_free();
  endtask

  task automatic check_model();
    repeat (6) @(negedge clk);  // room for a stray frame
    for (int m = 0; m < 2; m++) begin
      if (rx_q[m].size() != exp_q[m].size()) begin
        $display("ERROR %s: master %0d received %0d frames, model expects %0d", cur_test, m,
                 rx_q[m].size(), exp_q[m].size());
        errors++;
      end else begin
        for (int i = 0; i < rx_q[m].size(); i++) begin
          if (rx_q[m][i] !== exp_q[m][i]) begin
            $display("CHECK FAILED %s: master %0d frame %0d expected %b actual %b", cur_test,
                     m, i, exp_q[m][i], rx_q[m][i]);
            errors++;
          end
        end
      end
      rx_q[m].delete();
      exp_q[m].delete();
    end
    if (grant_q.size() != exp_grant.size()) begin
      $display("ERROR %s: %0d owner changes seen, model expects %0d", cur_test, grant_q.size(),
               exp_grant.size());
      errors++;
    end else begin
      for (int i = 0; i < grant_q.size(); i++) begin
        if (grant_q[i] !== exp_grant[i]) begin
          $display("CHECK FAILED %s: owner/slave_id %0d expected %b actual %b", cur_test, i,
                   exp_grant[i], grant_q[i]);
          errors++;
        end
      end
    end
    grant_q.delete();
    exp_grant.delete();
  endtask

  task automatic report(input int errs_before);
    tests++;
    if (errors != errs_before) failed_tests++;
    $display("test %-12s %s", cur_test, (errors == errs_before) ? "passed" : "failed");
  endtask

  initial begin
    int errs;
    void'($urandom(32'h344b));
    clk          = 1'b0;
    rstN         = 1'b0;
    go           = '0;
    prev_valid   = 1'b0;
    prev_owner   = 1'b0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    for (int m = 0; m < 2; m++) begin
      pat[m] = '0;
      len[m] = '0;
    end
    repeat (8) @(posedge clk);
    rstN <= 1'b1;

    cur_test = "reset";
    errs     = errors;
    for (int i = 0; i < 12; i++) begin
      @(negedge clk);
      if ({port_out, owner_valid} !== 3'b000) begin
        $display("CHECK FAILED %s: lines/owner_valid expected 000 actual %b", cur_test,
                 {port_out, owner_valid});
        errors++;
      end
    end
    check_model();
    report(errs);

    cur_test = "single_ack";
    errs     = errors;
    run_single(1, rand_id(), 1'b1);
    check_model();
    report(errs);

    cur_test = "nak";
    errs     = errors;
    run_single(0, rand_id(), 1'b0);
    run_single(1, rand_id(), 1'b1);  // bus free again
    check_model();
    report(errs);

    cur_test = "simultaneous";
    errs     = errors;
    run_both(rand_id(), 1'b1, rand_id(), 1'b1);
    check_model();
    report(errs);

    cur_test = "preempt";
    errs     = errors;
    run_preempt(rand_id(), 1'b1, rand_id());
    check_model();
    report(errs);

    cur_test = "random";
    errs     = errors;
    for (int i = 0; i < 200; i++) begin
      case ($urandom_range(2, 0))
        0: run_single(int'($urandom_range(1, 0)), rand_id(), rand_bit());
        1: run_both(rand_id(), rand_bit(), rand_id(), rand_bit());
        default: run_preempt(rand_id(), rand_bit(), rand_id());
      endcase
      check_model();
    end
    report(errs);

    $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
serial_arb_pkg.sv
frame_shifter.sv
master_port.sv
arb_controller.sv
serial_arbiter_top.sv
tb_master_line.sv
tb_serial_arbiter.sv

//--- run.sh
#!/bin/sh
# build and run with verilator, pass only if the log holds the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_serial_arbiter \
  -f list.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
grep -q "^Test OK$" sim.log
echo "simulation passed"
